/* project.f */
+incdir+verification
rtl/cuPkg.sv
rtl/instrDecoder.sv
rtl/microSequencer.sv
rtl/controlStore.sv
rtl/controlUnit.sv
verification/controlUnitTb.sv

/* rtl/controlStore.sv */
`timescale 1ns/1ps

module controlStore
(
	input  cuPkg::cuState      state,
	input  cuPkg::decodedInstr dec,
	output cuPkg::ctrlWord     ctrl
);
	import cuPkg::*;

	// every field is zero unless the state sets it
	always_comb
	begin
		ctrl = '0;
		case (state)
			resetSt:
			begin
				ctrl.loads.clr = 1'b1;
			end
			fetchAddr:
			begin
				ctrl.loads.marLd = 1'b1;
				ctrl.mem.rw = 1'b1;
			end
			// pc + 4 while the read is issued
			fetchInc:
			begin
				ctrl.loads.rfLd = 1'b1;
				ctrl.mem = '{rw: 1'b1, mov: 1'b1, size: wordSize};
				ctrl.mux.muxA = 2'b10;
				ctrl.mux.muxC = 3'b011;
				ctrl.mux.muxD = 1'b1;
				ctrl.op = 5'b10001;
			end
			fetchWait:
			begin
				ctrl.loads.irLd = 1'b1;
				ctrl.mem = '{rw: 1'b1, mov: 1'b1, size: wordSize};
			end
			dpImmOp:
			begin
				ctrl.loads.rfLd = 1'b1;
				ctrl.mux.muxB = 2'b01;
				ctrl.mux.muxC = 3'b100;
				ctrl.mux.muxD = 1'b1;
				ctrl.mux.muxF = 2'b11;
				ctrl.opType = 3'b001;
				ctrl.en = 1'b1;
				ctrl.op = 5'b10011;
			end
			dpImmWb:
			begin
				ctrl.loads.rfLd = 1'b1;
				ctrl.loads.frLd = dec.setFlags;
				ctrl.mux.muxI = 2'b10;
				ctrl.mux.muxJ = 2'b01;
				ctrl.opType = 3'b100;
			end
			dpShiftOp:
			begin
				ctrl.loads.rfLd = 1'b1;
				ctrl.loads.frLd = dec.setFlags;
				ctrl.mux.muxB = 2'b01;
				ctrl.mux.muxH = 1'b1;
				ctrl.mux.muxI = 2'b01;
			end
			// r14 <- pc before the jump
			brLinkSave:
			begin
				ctrl.loads.rfLd = 1'b1;
				ctrl.mux.muxA = 2'b11;
				ctrl.mux.muxC = 3'b010;
				ctrl.mux.muxD = 1'b1;
				ctrl.mux.muxJ = 2'b01;
				ctrl.shift = 6'b000100;
				ctrl.op = 5'b10000;
			end
			brTarget:
			begin
				ctrl.loads.rfLd = 1'b1;
				ctrl.mux.muxB = 2'b01;
				ctrl.mux.muxC = 3'b100;
				ctrl.mux.muxD = 1'b1;
				ctrl.mux.muxF = 2'b11;
				ctrl.mux.muxI = 2'b10;
				ctrl.mux.muxJ = 2'b10;
				ctrl.opType = 3'b100;
				ctrl.en = 1'b1;
				ctrl.op = 5'b10011;
			end
			brCommit:
			begin
				ctrl.loads.rfLd = 1'b1;
				ctrl.mux.muxA = 2'b10;
				ctrl.mux.muxB = 2'b01;
				ctrl.mux.muxC = 3'b011;
				ctrl.mux.muxD = 1'b1;
				ctrl.mux.muxI = 2'b10;
				ctrl.mux.muxJ = 2'b01;
				ctrl.opType = 3'b101;
				ctrl.shift = 6'b000100;
				ctrl.op = 5'b00100;
			end
			// base plus or minus the 12-bit offset
			lsAddr:
			begin
				ctrl.loads.marLd = 1'b1;
				ctrl.mux.muxB = 2'b01;
				ctrl.mux.muxD = 1'b1;
				ctrl.mux.muxF = 2'b11;
				ctrl.mux.muxI = 2'b10;
				ctrl.opType = 3'b101;
				ctrl.en = 1'b1;
				ctrl.op = dec.up ? 5'b00100 : 5'b00010;
			end
			lsReadReq:
			begin
				ctrl.mem = '{rw: 1'b1, mov: 1'b1, size: wordSize};
				ctrl.mux.muxI = 2'b10;
			end
			lsReadWait:
			begin
				ctrl.loads.mdrLd = 1'b1;
				ctrl.mem = '{rw: 1'b1, mov: 1'b1, size: wordSize};
				ctrl.mux.muxB = 2'b10;
				ctrl.mux.muxI = 2'b10;
			end
			lsLoadReg:
			begin
				ctrl.loads.rfLd = 1'b1;
				ctrl.mux.muxB = 2'b10;
				ctrl.mux.muxD = 1'b1;
				ctrl.mux.muxI = 2'b10;
				ctrl.op = 5'b10011;
			end
			// rd into mdr through the alu
			lsStoreData:
			begin
				ctrl.loads.mdrLd = 1'b1;
				ctrl.mux.muxA = 2'b01;
				ctrl.mux.muxB = 2'b11;
				ctrl.mux.muxD = 1'b1;
				ctrl.mux.muxE = 1'b1;
				ctrl.mux.muxI = 2'b10;
				ctrl.op = 5'b10000;
			end
			lsWriteWait:
			begin
				ctrl.mem = '{rw: 1'b0, mov: 1'b1, size: wordSize};
				ctrl.mux.muxI = 2'b10;
			end
			default:
			begin
				ctrl = '0;
			end
		endcase
	end

endmodule

/* rtl/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit
(
	input  logic            CLK,
	input  logic            rstN,
	input  cuPkg::instrWord ir,
	input  logic            cond,
	input  logic            moc,
	output cuPkg::ctrlWord  ctrl
);
	import cuPkg::*;

	decodedInstr dec;
	cuState state;

	instrDecoder decoder
	(
		.ir  (ir),
		.dec (dec)
	);

	// only the sequencer sees cond and moc
	microSequencer sequencer
	(
		.CLK   (CLK),
		.rstN  (rstN),
		.dec   (dec),
		.cond  (cond),
		.moc   (moc),
		.state (state)
	);

	controlStore store
	(
		.state (state),
		.dec   (dec),
		.ctrl  (ctrl)
	);

endmodule

/* rtl/cuPkg.sv */
package cuPkg;

	// widths that carry a meaning
	typedef logic [31:0] instrWord;
	typedef logic [2:0]  condBits;
	typedef logic [4:0]  aluOp;
	typedef logic [5:0]  shiftSel;
	typedef logic [2:0]  tSel;
	typedef logic [1:0]  memSize;

	// only word transfers are issued
	localparam memSize wordSize = 2'b10;

	// encodings follow bits 27:25 where a class has one
	typedef enum logic [2:0]
	{
		dpShift     = 3'b000,
		dpImm       = 3'b001,
		lsImm       = 3'b010,
		branch      = 3'b101,
		unsupported = 3'b111
	} instrClass;

	typedef enum logic [4:0]
	{
		resetSt,
		fetchAddr,
		fetchInc,
		fetchWait,
		decode,
		dpImmOp,
		dpImmWb,
		dpShiftOp,
		brTarget,
		brLinkSave,
		brCommit,
		lsAddr,
		lsReadReq,
		lsReadWait,
		lsLoadReg,
		lsStoreData,
		lsWriteWait
	} cuState;

	// bit 20 appears twice, S for data processing and L for transfers
	typedef struct packed
	{
		instrClass iClass;
		logic      setFlags;
		logic      load;
		logic      link;
		logic      up;
	} decodedInstr;

	typedef struct packed
	{
		logic clr;
		logic rfLd;
		logic irLd;
		logic marLd;
		logic mdrLd;
		logic frLd;
	} regLoads;

	// rw high is a read
	typedef struct packed
	{
		logic   rw;
		logic   mov;
		memSize size;
	} memCtrl;

	typedef struct packed
	{
		logic [1:0] muxA;
		logic [1:0] muxB;
		logic [2:0] muxC;
		logic       muxD;
		logic       muxE;
		logic [1:0] muxF;
		logic       muxG;
		logic       muxH;
		logic [1:0] muxI;
		logic [1:0] muxJ;
	} muxSel;

	typedef struct packed
	{
		regLoads loads;
		memCtrl  mem;
		muxSel   mux;
		aluOp    op;
		shiftSel shift;
		tSel     opType;
		logic    en;
	} ctrlWord;

endpackage

/* rtl/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder
(
	input  cuPkg::instrWord    ir,
	output cuPkg::decodedInstr dec
);
	import cuPkg::*;

	condBits classField;
	instrClass iClass;

	assign classField = ir[27:25];

	// anything outside the kept classes goes back to fetch
	always_comb
	begin
		case (classField)
			3'b000:
			begin
				iClass = dpShift;
			end
			3'b001:
			begin
				iClass = dpImm;
			end
			3'b010:
			begin
				iClass = lsImm;
			end
			3'b101:
			begin
				iClass = branch;
			end
			default:
			begin
				iClass = unsupported;
			end
		endcase
	end

	always_comb
	begin
		dec.iClass = iClass;
		// S bit for data processing
		dec.setFlags = ir[20];
		// L bit for load/store
		dec.load = ir[20];
		dec.link = ir[24];
		// U bit adds the offset when set
		dec.up = ir[23];
	end

endmodule

/* rtl/microSequencer.sv */
`timescale 1ns/1ps

module microSequencer
(
	input  logic               CLK,
	input  logic               rstN,
	input  cuPkg::decodedInstr dec,
	input  logic               cond,
	input  logic               moc,
	output cuPkg::cuState      state
);
	import cuPkg::*;

	cuState nextState;

	always_ff @(posedge CLK or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= resetSt;
		end
		else
		begin
			state <= nextState;
		end
	end

	always_comb
	begin
		nextState = state;
		case (state)
			resetSt:
			begin
				nextState = fetchAddr;
			end
			fetchAddr:
			begin
				nextState = fetchInc;
			end
			fetchInc:
			begin
				nextState = fetchWait;
			end
			// hold until memory answers
			fetchWait:
			begin
				if (moc)
				begin
					nextState = decode;
				end
			end
			decode:
			begin
				if (!cond)
				begin
					// condition failed, skip the instruction
					nextState = fetchAddr;
				end
				else
				begin
					case (dec.iClass)
						dpImm:
						begin
							nextState = dpImmOp;
						end
						dpShift:
						begin
							nextState = dpShiftOp;
						end
						branch:
						begin
							nextState = dec.link ? brLinkSave : brTarget;
						end
						lsImm:
						begin
							nextState = lsAddr;
						end
						default:
						begin
							nextState = fetchAddr;
						end
					endcase
				end
			end
			dpImmOp:
			begin
				nextState = dpImmWb;
			end
			dpImmWb:
			begin
				nextState = fetchAddr;
			end
			dpShiftOp:
			begin
				nextState = fetchAddr;
			end
			brLinkSave:
			begin
				nextState = brTarget;
			end
			brTarget:
			begin
				nextState = brCommit;
			end
			brCommit:
			begin
				nextState = fetchAddr;
			end
			lsAddr:
			begin
				nextState = dec.load ? lsReadReq : lsStoreData;
			end
			lsReadReq:
			begin
				nextState = lsReadWait;
			end
			lsReadWait:
			begin
				if (moc)
				begin
					nextState = lsLoadReg;
				end
			end
			lsLoadReg:
			begin
				nextState = fetchAddr;
			end
			lsStoreData:
			begin
				nextState = lsWriteWait;
			end
			lsWriteWait:
			begin
				if (moc)
				begin
					nextState = fetchAddr;
				end
			end
			default:
			begin
				nextState = resetSt;
			end
		endcase
	end

endmodule

/* verification/cuTbTable.svh */
`ifndef CU_TB_TABLE_SVH
`define CU_TB_TABLE_SVH

// the columns are ir, cond, rfLd cycles, frLd cycles, mdrLd bursts, write-request bursts,
// cycles from decode to the next fetchAddr (0 where memory timing decides)
// and the ALU op expected in lsAddr (00100 adds and 00010 subtracts)
typedef struct packed
{
	cuPkg::instrWord ir;
	logic            cond;
	logic [3:0]      rfCnt;
	logic [3:0]      frCnt;
	logic [3:0]      mdrBursts;
	logic [3:0]      wrBursts;
	logic [3:0]      cycles;
	cuPkg::aluOp     lsOp;
} tableRow;

localparam int numRows = 18;

tableRow rows [0:numRows-1] = '{
	'{32'hE281_1001, 1'b1, 4'd2, 4'd0, 4'd0, 4'd0, 4'd4, 5'b00000},
	'{32'hE291_1001, 1'b1, 4'd2, 4'd1, 4'd0, 4'd0, 4'd4, 5'b00000},
	'{32'hE1A0_1102, 1'b1, 4'd1, 4'd0, 4'd0, 4'd0, 4'd3, 5'b00000},
	'{32'hE1B0_1102, 1'b1, 4'd1, 4'd1, 4'd0, 4'd0, 4'd3, 5'b00000},
	'{32'hEA00_0004, 1'b1, 4'd2, 4'd0, 4'd0, 4'd0, 4'd4, 5'b00000},
	'{32'hEB00_0004, 1'b1, 4'd3, 4'd0, 4'd0, 4'd0, 4'd5, 5'b00000},
	'{32'hE592_1004, 1'b1, 4'd1, 4'd0, 4'd1, 4'd0, 4'd0, 5'b00100},
	'{32'hE512_1004, 1'b1, 4'd1, 4'd0, 4'd1, 4'd0, 4'd0, 5'b00010},
	'{32'hE582_1004, 1'b1, 4'd0, 4'd0, 4'd1, 4'd1, 4'd0, 5'b00100},
	'{32'hE502_1004, 1'b1, 4'd0, 4'd0, 4'd1, 4'd1, 4'd0, 5'b00010},
	'{32'h0291_1001, 1'b0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd2, 5'b00000},
	'{32'h0B00_0004, 1'b0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd2, 5'b00000},
	'{32'h0592_1004, 1'b0, 4'd0, 4'd0, 4'd0, 4'd0, 4'd2, 5'b00000},
	'{32'hE600_0010, 1'b1, 4'd0, 4'd0, 4'd0, 4'd0, 4'd2, 5'b00000},
	'{32'hE890_0006, 1'b1, 4'd0, 4'd0, 4'd0, 4'd0, 4'd2, 5'b00000},
	'{32'hEF00_0000, 1'b1, 4'd0, 4'd0, 4'd0, 4'd0, 4'd2, 5'b00000},
	'{32'hE593_1008, 1'b1, 4'd1, 4'd0, 4'd1, 4'd0, 4'd0, 5'b00100},
	'{32'hE583_1008, 1'b1, 4'd0, 4'd0, 4'd1, 4'd1, 4'd0, 5'b00100}
};

`endif

/* verification/controlUnitTb.sv */
`timescale 1ns/1ps

module controlUnitTb;
	import cuPkg::*;

	localparam int waitLimit = 40;

	logic     CLK;
	logic     rstN;
	instrWord ir;
	logic     cond;
	logic     moc;
	ctrlWord  ctrl;

	int ctrlErrors;
	int countErrors;
	int timeoutErrors;
	bit timedOut;

	`include "cuTbTable.svh"

	controlUnit uut
	(
		.CLK  (CLK),
		.rstN (rstN),
		.ir   (ir),
		.cond (cond),
		.moc  (moc),
		.ctrl (ctrl)
	);

	initial
	begin
		CLK = 1'b0;
		forever
		begin
			#2 CLK = ~CLK;
		end
	end

	// memory model that answers each request with one moc pulse after a random delay
	initial
	begin
		int unsigned waitLeft;
		bit busy;
		bit served;
		void'($urandom(32'h324b_2e40));
		busy = 1'b0;
		served = 1'b0;
		waitLeft = 0;
		forever
		begin
			@(posedge CLK);
			#1;
			if (!ctrl.mem.mov)
			begin
				served = 1'b0;
			end
			if (moc)
			begin
				moc = 1'b0;
			end
			else if (busy)
			begin
				if (waitLeft == 0)
				begin
					moc = 1'b1;
					busy = 1'b0;
					served = 1'b1;
				end
				else
				begin
					waitLeft--;
				end
			end
			else if (ctrl.mem.mov && !served)
			begin
				busy = 1'b1;
				waitLeft = $urandom % 4;
			end
		end
	end

	task automatic checkCtrl(input string name, input ctrlWord got, input ctrlWord exp,
		input ctrlWord care);
		if (((got ^ exp) & care) !== '0)
		begin
			ctrlErrors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got & care,
				exp & care);
		end
	endtask

	task automatic checkCount(input string name, input int got, input int exp);
		if (got != exp)
		begin
			countErrors++;
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic reportTimeout(input string what);
		timeoutErrors++;
		timedOut = 1'b1;
		$display("Timeout at %0t: %s", $time, what);
	endtask

	// fetchWait keeps irLd, mov and rw up with a word size and never loads mar
	task automatic waitFetch(input int row);
		ctrlWord exp;
		ctrlWord care;
		int n;
		bit done;
		exp = '0;
		care = '0;
		exp.loads.irLd = 1'b1;
		exp.mem.mov = 1'b1;
		exp.mem.rw = 1'b1;
		exp.mem.size = wordSize;
		care.loads.irLd = 1'b1;
		care.loads.marLd = 1'b1;
		care.mem.mov = 1'b1;
		care.mem.rw = 1'b1;
		care.mem.size = '1;
		done = 1'b0;
		for (n = 0; n < waitLimit && !done; n++)
		begin
			@(negedge CLK);
			if (ctrl.loads.irLd)
			begin
				checkCtrl($sformatf("row %0d ctrl in fetch wait", row), ctrl, exp, care);
				done = moc;
			end
		end
		if (!done)
		begin
			reportTimeout($sformatf("row %0d never finished its instruction fetch", row));
		end
	endtask

	// strobes between the fetch and the next fetchAddr
	task automatic countRow(input int row);
		ctrlWord exp;
		ctrlWord care;
		ctrlWord opExp;
		ctrlWord opCare;
		int rf;
		int fr;
		int mdrB;
		int wrB;
		int cycles;
		logic prevMdr;
		logic prevWr;
		logic prevWait;
		logic prevRw;
		bit done;
		exp = '0;
		care = '0;
		exp.mem.mov = 1'b1;
		exp.mem.size = wordSize;
		care.mem.mov = 1'b1;
		care.mem.rw = 1'b1;
		care.mem.size = '1;
		opExp = '0;
		opCare = '0;
		opExp.op = rows[row].lsOp;
		opCare.op = '1;
		rf = 0;
		fr = 0;
		mdrB = 0;
		wrB = 0;
		cycles = 0;
		prevMdr = 1'b0;
		prevWr = 1'b0;
		prevWait = 1'b0;
		prevRw = 1'b0;
		done = 1'b0;
		while (!done && cycles < waitLimit)
		begin
			@(negedge CLK);
			cycles++;
			// a request without moc must still be there
			if (prevWait)
			begin
				exp.mem.rw = prevRw;
				checkCtrl($sformatf("row %0d ctrl in memory wait", row), ctrl, exp, care);
			end
			// only lsAddr loads mar with rw low
			if (ctrl.loads.marLd && !ctrl.mem.rw)
			begin
				checkCtrl($sformatf("row %0d ctrl op in lsAddr", row), ctrl, opExp, opCare);
			end
			rf += ctrl.loads.rfLd;
			fr += ctrl.loads.frLd;
			if (ctrl.loads.mdrLd && !prevMdr)
			begin
				mdrB++;
			end
			if (ctrl.mem.mov && !ctrl.mem.rw && !prevWr)
			begin
				wrB++;
			end
			prevMdr = ctrl.loads.mdrLd;
			prevWr = ctrl.mem.mov && !ctrl.mem.rw;
			prevWait = ctrl.mem.mov && !moc;
			prevRw = ctrl.mem.rw;
			// lsAddr also loads mar, but with rw low
			done = ctrl.loads.marLd && ctrl.mem.rw;
		end
		if (!done)
		begin
			reportTimeout($sformatf("row %0d never returned to fetchAddr", row));
		end
		else
		begin
			checkCount($sformatf("row %0d rfLd cycles", row), rf, rows[row].rfCnt);
			checkCount($sformatf("row %0d frLd cycles", row), fr, rows[row].frCnt);
			checkCount($sformatf("row %0d mdrLd bursts", row), mdrB, rows[row].mdrBursts);
			checkCount($sformatf("row %0d write requests", row), wrB, rows[row].wrBursts);
			if (rows[row].cycles != 0)
			begin
				checkCount($sformatf("row %0d cycles to fetchAddr", row), cycles,
					rows[row].cycles);
			end
		end
	endtask

	initial
	begin
		ctrlWord expWord;
		int cyc;
		int row;
		rstN = 1'b0;
		ir = '0;
		cond = 1'b0;
		moc = 1'b0;
		ctrlErrors = 0;
		countErrors = 0;
		timeoutErrors = 0;
		timedOut = 1'b0;
		expWord = '0;
		expWord.loads.clr = 1'b1;
		for (cyc = 0; cyc < 4; cyc++)
		begin
			@(negedge CLK);
			checkCtrl("ctrl in reset", ctrl, expWord, '1);
		end
		@(posedge CLK);
		#1;
		rstN = 1'b1;
		@(negedge CLK);
		checkCtrl("ctrl on first cycle after reset", ctrl, expWord, '1);
		@(negedge CLK);
		expWord = '0;
		expWord.loads.marLd = 1'b1;
		expWord.mem.rw = 1'b1;
		checkCtrl("ctrl in fetchAddr", ctrl, expWord, '1);
		for (row = 0; row < numRows && !timedOut; row++)
		begin
			@(posedge CLK);
			#1;
			ir = rows[row].ir;
			cond = rows[row].cond;
			waitFetch(row);
			if (!timedOut)
			begin
				countRow(row);
			end
		end
		$display("Errors: ctrl %0d, count %0d, timeout %0d", ctrlErrors, countErrors,
			timeoutErrors);
		if (ctrlErrors + countErrors + timeoutErrors == 0)
		begin
			$display("Simulation PASSED");
		end
		else
		begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule
